// ==== rtl/fetch_defs.svh ====
// ------------------------------------------------
// project-wide sizes and RV32 opcodes of the fetch
// frontend. every size must be a power of two
// ------------------------------------------------

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// virtual address width
`define FETCH_VLEN 32

// bimodal table, indexed by pc bits above bit 1
`define FETCH_BHT_ENTRIES 16

// return address stack depth
`define FETCH_RAS_DEPTH 2

// entries between fetch and decode
`define FETCH_QUEUE_DEPTH 4

// major opcodes of the 32-bit control-flow instructions
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_JAL    7'b1101111
`define FETCH_OP_JALR   7'b1100111

`endif

// ==== rtl/fetch_pkg.sv ====
// ------------------------------------------------
// shared types of the fetch frontend
// widths come from fetch_defs.svh
// ------------------------------------------------

`include "fetch_defs.svh"

package fetch_pkg;

    // control-flow kind of one instruction
    typedef enum logic [2:0] {
        NoCF,
        Branch,
        Jump,
        JumpR,
        Return
    } cf_type_e;

    // request toward the instruction cache
    typedef struct packed {
        logic                   req;
        logic                   kill_s1;
        logic                   kill_s2;
        logic [`FETCH_VLEN-1:0] vaddr;
    } icache_req_t;

    // cache answer, one cycle after acceptance
    typedef struct packed {
        logic                   ready;
        logic                   valid;
        logic [31:0]            data;
        logic [`FETCH_VLEN-1:0] vaddr;
    } icache_rsp_t;

    // branch resolved in the backend
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_VLEN-1:0] pc;
        logic [`FETCH_VLEN-1:0] target;
        logic                   is_taken;
        logic                   is_mispredict;
        cf_type_e               cf_type;
    } resolve_t;

    // scan result, valid means the redirect is taken
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_VLEN-1:0] target;
        cf_type_e               cf_type;
        logic                   push;
        logic [`FETCH_VLEN-1:0] push_addr;
    } predict_t;

    // entry handed to decode
    typedef struct packed {
        logic [`FETCH_VLEN-1:0] address;
        logic [31:0]            instr;
        logic [`FETCH_VLEN-1:0] predict_address;
        cf_type_e               cf_type;
    } fetch_entry_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

endpackage

// ==== rtl/pc_gen.sv ====
// ------------------------------------------------
// next-pc selection and cache request port
// req stays high, the cache decides acceptance
// redirects land on vaddr one cycle later
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module pc_gen (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [`FETCH_VLEN-1:0] boot_addr_i,
    input  fetch_pkg::resolve_t    resolved_branch_i,
    input  fetch_pkg::predict_t    predict_i,
    input  logic                   if_ready_i,
    input  logic                   replay_i,
    input  logic [`FETCH_VLEN-1:0] replay_addr_i,
    input  logic                   eret_i,
    input  logic [`FETCH_VLEN-1:0] epc_i,
    input  logic                   ex_valid_i,
    input  logic [`FETCH_VLEN-1:0] trap_vector_base_i,
    input  logic                   set_pc_commit_i,
    input  logic [`FETCH_VLEN-1:0] pc_commit_i,
    input  logic                   flush_i,
    output fetch_pkg::icache_req_t icache_req_o
);

    logic [`FETCH_VLEN-1:0] npc_d, npc_q;
    logic [`FETCH_VLEN-1:0] fetch_addr;
    // set out of reset so the first request uses boot_addr_i
    logic                   boot_load_q;
    logic                   mispredict;

    assign mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;

    // --------------------------------------------
    // next pc, later assignments win
    // --------------------------------------------
    always_comb begin
        fetch_addr = boot_load_q ? boot_addr_i : npc_q;
        // taken prediction redirects the request in the same cycle
        if (predict_i.valid) begin
            fetch_addr = predict_i.target;
        end
        npc_d = fetch_addr;
        if (if_ready_i) begin
            npc_d = {fetch_addr[`FETCH_VLEN-1:2], 2'b00} + `FETCH_VLEN'd4;
        end
        // queue was full, fetch the dropped address again
        if (replay_i) npc_d = replay_addr_i;
        if (mispredict) npc_d = resolved_branch_i.target;
        if (eret_i) npc_d = epc_i;
        // trap wins over a simultaneous eret
        if (ex_valid_i) npc_d = trap_vector_base_i;
        // csr side effects restart after the committing instruction
        if (set_pc_commit_i) npc_d = pc_commit_i + `FETCH_VLEN'd4;
    end

    assign icache_req_o.req     = 1'b1;
    assign icache_req_o.vaddr   = fetch_addr;
    // drop the request of this cycle
    assign icache_req_o.kill_s1 = mispredict | flush_i | replay_i;
    // drop the response arriving now, fall-through of a taken prediction
    assign icache_req_o.kill_s2 = icache_req_o.kill_s1 | predict_i.valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q <= 1'b1;
            npc_q       <= '0;
        end else begin
            boot_load_q <= 1'b0;
            npc_q       <= npc_d;
        end
    end

    // a killed fetch must not come back as a prediction
    a_kill_inclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        icache_req_o.kill_s1 |=> !predict_i.valid);

endmodule

// ==== rtl/branch_scan.sv ====
// ------------------------------------------------
// decodes one 32-bit instruction, no compressed
// jalr other than a return is left unpredicted
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module branch_scan (
    input  logic                   fetch_valid_i,
    input  logic [`FETCH_VLEN-1:0] fetch_addr_i,
    input  logic [31:0]            fetch_instr_i,
    input  fetch_pkg::bht_pred_t   bht_i,
    input  logic [`FETCH_VLEN-1:0] ras_top_i,
    input  logic                   ras_valid_i,
    input  logic                   consumed_i,
    output fetch_pkg::predict_t    predict_o,
    output logic                   ras_pop_o
);

    logic [6:0]             opcode;
    logic                   rd_link, rs1_link;
    logic                   is_branch, is_jal, is_jalr, is_call, is_return;
    logic [`FETCH_VLEN-1:0] imm_b, imm_j;
    logic                   branch_taken;

    assign opcode   = fetch_instr_i[6:0];
    // x1 and x5 are the link registers
    assign rd_link  = (fetch_instr_i[11:7] == 5'd1) || (fetch_instr_i[11:7] == 5'd5);
    assign rs1_link = (fetch_instr_i[19:15] == 5'd1) || (fetch_instr_i[19:15] == 5'd5);

    assign is_branch = fetch_valid_i && (opcode == `FETCH_OP_BRANCH);
    assign is_jal    = fetch_valid_i && (opcode == `FETCH_OP_JAL);
    assign is_jalr   = fetch_valid_i && (opcode == `FETCH_OP_JALR);
    assign is_call   = (is_jal | is_jalr) & rd_link;
    assign is_return = is_jalr & rs1_link & ~rd_link;

    // sign-extended b and j immediates
    assign imm_b = {{(`FETCH_VLEN-12){fetch_instr_i[31]}}, fetch_instr_i[7],
                    fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};
    assign imm_j = {{(`FETCH_VLEN-20){fetch_instr_i[31]}}, fetch_instr_i[19:12],
                    fetch_instr_i[20], fetch_instr_i[30:21], 1'b0};

    // dynamic prediction if the bht knows it, else backward taken
    assign branch_taken = bht_i.valid ? bht_i.taken : imm_b[`FETCH_VLEN-1];

    always_comb begin
        predict_o.valid     = 1'b0;
        predict_o.target    = '0;
        predict_o.cf_type   = fetch_pkg::NoCF;
        // ras only moves for instructions the queue took
        predict_o.push      = is_call & consumed_i;
        predict_o.push_addr = fetch_addr_i + `FETCH_VLEN'd4;
        ras_pop_o           = 1'b0;
        if (is_branch && branch_taken) begin
            predict_o.valid   = 1'b1;
            predict_o.target  = fetch_addr_i + imm_b;
            predict_o.cf_type = fetch_pkg::Branch;
        end else if (is_jal) begin
            predict_o.valid   = 1'b1;
            predict_o.target  = fetch_addr_i + imm_j;
            predict_o.cf_type = fetch_pkg::Jump;
        end else if (is_return && ras_valid_i) begin
            predict_o.valid   = 1'b1;
            predict_o.target  = ras_top_i;
            predict_o.cf_type = fetch_pkg::Return;
            ras_pop_o         = consumed_i;
        end
    end

endmodule

// ==== rtl/bht.sv ====
// ------------------------------------------------
// bimodal table of 2-bit saturating counters
// only resolved conditional branches train it
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module bht (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic [`FETCH_VLEN-1:0] vpc_i,
    input  fetch_pkg::resolve_t    update_i,
    output fetch_pkg::bht_pred_t   pred_o
);

    localparam int unsigned IdxW = $clog2(`FETCH_BHT_ENTRIES);

    logic [`FETCH_BHT_ENTRIES-1:0] valid_q;
    logic [1:0]                    cnt_q [`FETCH_BHT_ENTRIES];
    logic [IdxW-1:0]               rd_idx, wr_idx;
    logic                          upd;

    // word index, bits 1:0 are always zero
    assign rd_idx = vpc_i[IdxW+1:2];
    assign wr_idx = update_i.pc[IdxW+1:2];
    assign upd    = update_i.valid && (update_i.cf_type == fetch_pkg::Branch);

    assign pred_o.valid = valid_q[rd_idx];
    assign pred_o.taken = cnt_q[rd_idx][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (upd) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // counters count toward the outcome
    always_ff @(posedge clk_i) begin
        if (upd) begin
            if (!valid_q[wr_idx] || flush_i) begin
                // first sighting, weak state in the resolved direction
                cnt_q[wr_idx] <= update_i.is_taken ? 2'b10 : 2'b01;
            end else if (update_i.is_taken && cnt_q[wr_idx] != 2'b11) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
            end else if (!update_i.is_taken && cnt_q[wr_idx] != 2'b00) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
            end
        end
    end

endmodule

// ==== rtl/ras.sv ====
// ------------------------------------------------
// shift-register return address stack
// overflow drops the oldest entry
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module ras (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   push_i,
    input  logic                   pop_i,
    input  logic [`FETCH_VLEN-1:0] data_i,
    output logic [`FETCH_VLEN-1:0] top_o,
    output logic                   valid_o
);

    logic [`FETCH_VLEN-1:0]      addr_q [`FETCH_RAS_DEPTH];
    logic [`FETCH_RAS_DEPTH-1:0] vld_q;

    assign top_o   = addr_q[0];
    assign valid_o = vld_q[0];

    // valid bits, entry 0 is the top
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q <= '0;
        end else if (flush_i) begin
            vld_q <= '0;
        end else if (push_i && pop_i) begin
            vld_q[0] <= 1'b1;
        end else if (push_i) begin
            vld_q <= {vld_q[`FETCH_RAS_DEPTH-2:0], 1'b1};
        end else if (pop_i) begin
            vld_q <= {1'b0, vld_q[`FETCH_RAS_DEPTH-1:1]};
        end
    end

    // addresses follow the same shifts
    always_ff @(posedge clk_i) begin
        if (push_i && pop_i) begin
            // call right after return, replace the top
            addr_q[0] <= data_i;
        end else if (push_i) begin
            for (int i = `FETCH_RAS_DEPTH-1; i > 0; i--) begin
                addr_q[i] <= addr_q[i-1];
            end
            addr_q[0] <= data_i;
        end else if (pop_i) begin
            for (int i = 0; i < `FETCH_RAS_DEPTH-1; i++) begin
                addr_q[i] <= addr_q[i+1];
            end
        end
    end

    // the scanner only pops a valid prediction
    a_no_empty_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i && !push_i |-> valid_o);

endmodule

// ==== rtl/fetch_queue.sv ====
// ------------------------------------------------
// circular fifo from fetch to decode
// a fetch that finds it full is dropped and replayed
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_queue (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  logic [`FETCH_VLEN-1:0]  addr_i,
    input  logic [31:0]             instr_i,
    input  fetch_pkg::predict_t     predict_i,
    input  logic                    fetch_entry_ready_i,
    output logic                    consumed_o,
    output logic                    ready_o,
    output logic                    replay_o,
    output logic [`FETCH_VLEN-1:0]  replay_addr_o,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o
);

    localparam int unsigned PtrW = $clog2(`FETCH_QUEUE_DEPTH);

    fetch_pkg::fetch_entry_t mem_q [`FETCH_QUEUE_DEPTH];
    logic [PtrW-1:0]         rd_ptr_q, wr_ptr_q;
    logic [PtrW:0]           count_q;
    logic                    full, push, pop;

    assign full = (count_q == (PtrW+1)'(`FETCH_QUEUE_DEPTH));
    assign push = valid_i & ~full & ~flush_i;
    assign pop  = fetch_entry_valid_o & fetch_entry_ready_i & ~flush_i;

    assign consumed_o    = push;
    assign replay_o      = valid_i & full & ~flush_i;
    assign replay_addr_o = addr_i;
    // two free slots so the fetch already in flight still fits
    assign ready_o       = (count_q <= (PtrW+1)'(`FETCH_QUEUE_DEPTH - 2));

    assign fetch_entry_valid_o = (count_q != '0);
    assign fetch_entry_o       = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q].address         <= addr_i;
            mem_q[wr_ptr_q].instr           <= instr_i;
            mem_q[wr_ptr_q].predict_address <= predict_i.target;
            mem_q[wr_ptr_q].cf_type         <= predict_i.cf_type;
        end
    end

    // count stays within the depth and agrees with the pointers
    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= (PtrW+1)'(`FETCH_QUEUE_DEPTH)
        && count_q[PtrW-1:0] == PtrW'(wr_ptr_q - rd_ptr_q));

    // decode sees the same entry until it takes it
    a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_entry_valid_o && !fetch_entry_ready_i && !flush_i
        |=> $stable(fetch_entry_o) || !fetch_entry_valid_o);

endmodule

// ==== rtl/fetch_frontend.sv ====
// ------------------------------------------------
// fetch frontend top, one instruction per fetch
// flush_i from the backend also kills the cache
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_frontend (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    flush_bp_i,
    input  logic [`FETCH_VLEN-1:0]  boot_addr_i,
    input  fetch_pkg::resolve_t     resolved_branch_i,
    input  logic                    set_pc_commit_i,
    input  logic [`FETCH_VLEN-1:0]  pc_commit_i,
    input  logic [`FETCH_VLEN-1:0]  epc_i,
    input  logic                    eret_i,
    input  logic [`FETCH_VLEN-1:0]  trap_vector_base_i,
    input  logic                    ex_valid_i,
    output fetch_pkg::icache_req_t  icache_req_o,
    input  fetch_pkg::icache_rsp_t  icache_rsp_i,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o,
    input  logic                    fetch_entry_ready_i
);

    // fetch-stage register
    logic                   fetch_valid;
    logic [`FETCH_VLEN-1:0] fetch_addr;
    logic [31:0]            fetch_instr;
    // queue had room when the answered request was accepted
    logic                   req_adv_q;
    logic                   capture;

    fetch_pkg::predict_t    predict;
    fetch_pkg::bht_pred_t   bht_pred;
    logic [`FETCH_VLEN-1:0] ras_top, replay_addr;
    logic                   ras_valid, ras_pop;
    logic                   queue_ready, consumed, replay, queue_flush;

    // a request taken without advancing the pc is fetched again, drop its answer
    assign capture     = icache_rsp_i.valid & ~icache_req_o.kill_s2 & req_adv_q;
    assign queue_flush = flush_i | (resolved_branch_i.valid & resolved_branch_i.is_mispredict);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_valid <= 1'b0;
            req_adv_q   <= 1'b0;
        end else begin
            fetch_valid <= capture;
            req_adv_q   <= queue_ready;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            fetch_addr  <= icache_rsp_i.vaddr;
            fetch_instr <= icache_rsp_i.data;
        end
    end

    pc_gen i_pc_gen (
        .clk_i, .rst_ni, .boot_addr_i, .resolved_branch_i,
        .predict_i          ( predict                           ),
        .if_ready_i         ( icache_rsp_i.ready & queue_ready ),
        .replay_i           ( replay                            ),
        .replay_addr_i      ( replay_addr                       ),
        .eret_i, .epc_i, .ex_valid_i, .trap_vector_base_i,
        .set_pc_commit_i, .pc_commit_i, .flush_i, .icache_req_o
    );

    branch_scan i_branch_scan (
        .fetch_valid_i ( fetch_valid ), .fetch_addr_i ( fetch_addr ),
        .fetch_instr_i ( fetch_instr ), .bht_i        ( bht_pred   ),
        .ras_top_i     ( ras_top     ), .ras_valid_i  ( ras_valid  ),
        .consumed_i    ( consumed    ), .predict_o    ( predict    ),
        .ras_pop_o     ( ras_pop     )
    );

    bht i_bht (
        .clk_i, .rst_ni,
        .flush_i  ( flush_bp_i        ),
        .vpc_i    ( fetch_addr        ),
        .update_i ( resolved_branch_i ),
        .pred_o   ( bht_pred          )
    );

    ras i_ras (
        .clk_i, .rst_ni,
        .flush_i ( flush_bp_i        ), .push_i  ( predict.push ),
        .pop_i   ( ras_pop           ), .data_i  ( predict.push_addr ),
        .top_o   ( ras_top           ), .valid_o ( ras_valid    )
    );

    fetch_queue i_fetch_queue (
        .clk_i, .rst_ni,
        .flush_i       ( queue_flush ), .valid_i       ( fetch_valid ),
        .addr_i        ( fetch_addr  ), .instr_i       ( fetch_instr ),
        .predict_i     ( predict     ), .fetch_entry_ready_i,
        .consumed_o    ( consumed    ), .ready_o       ( queue_ready ),
        .replay_o      ( replay      ), .replay_addr_o ( replay_addr ),
        .fetch_entry_o, .fetch_entry_valid_o
    );

endmodule

// ==== dv/tb_fetch_frontend.sv ====
// ------------------------------------------------
// testbench of the fetch frontend, boot at 0x1000
// program loops 0x1010..0x1040 with a call/return
// concurrent assertions check every decoded entry
// ------------------------------------------------

`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch_frontend;

    localparam logic [31:0] BootAddr = 32'h1000;
    // summed test lengths in decoded entries
    localparam int TestLen = 80 + 20 + 20 + 10 + 16;

    logic clk_i, rst_ni, flush_i, flush_bp_i, eret_i, ex_valid_i, set_pc_commit_i;
    logic [31:0] epc_i, trap_vector_base_i, pc_commit_i;
    fetch_pkg::resolve_t     rb;
    fetch_pkg::icache_req_t  icache_req;
    fetch_pkg::icache_rsp_t  icache_rsp;
    fetch_pkg::fetch_entry_t entry;
    logic entry_valid, entry_ready;

    // cache model state and random source
    logic        acc_q;
    logic [31:0] acc_addr_q, rnd;
    logic        slow_decode;
    // monitor state
    logic        take, flush_now, chk_valid;
    logic [31:0] exp_addr, chk_addr, chk_target;
    fetch_pkg::cf_type_e chk_cf;
    logic [15:0] trained;
    int          taken_cnt, errors, err_start, tests;
    string       cur_test;

    fetch_frontend i_fetch_frontend (
        .clk_i, .rst_ni, .flush_i, .flush_bp_i, .boot_addr_i ( BootAddr ),
        .resolved_branch_i ( rb ), .set_pc_commit_i, .pc_commit_i, .epc_i, .eret_i,
        .trap_vector_base_i, .ex_valid_i,
        .icache_req_o ( icache_req ), .icache_rsp_i ( icache_rsp ),
        .fetch_entry_o ( entry ), .fetch_entry_valid_o ( entry_valid ),
        .fetch_entry_ready_i ( entry_ready )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], `FETCH_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `FETCH_OP_JAL};
    endfunction

    // offsets of the two jal instructions in the program
    function automatic logic [20:0] jal_imm(input logic [31:0] a);
        case (a)
            32'h1000: return 21'h10;
            32'h1020: return 21'h100;
            default:  return 21'h0;
        endcase
    endfunction

    // instruction at each address, nops carry address bits in their immediate
    function automatic logic [31:0] program_word(input logic [31:0] a);
        logic [11:0] imm;
        imm = a[11:0] ^ a[23:12] ^ {a[31:24], 4'h0};
        case (a)
            32'h1000: return enc_jal(5'd0, jal_imm(a));
            32'h1010: return enc_branch(13'd8);
            32'h1020: return enc_jal(5'd1, jal_imm(a));
            32'h1124: return {12'd0, 5'd1, 3'b000, 5'd0, `FETCH_OP_JALR};
            32'h1040: return enc_branch(13'h1fd0);
            default:  return {imm, 5'd0, 3'b000, 5'd0, 7'b0010011};
        endcase
    endfunction

    // target of a jal in the program, the offset is signed
    function automatic logic [31:0] jal_target(input logic [31:0] a);
        logic [20:0] imm;
        imm = jal_imm(a);
        return a + {{11{imm[20]}}, imm};
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // cache model and random ready levels
    // --------------------------------------------------
    always @(posedge clk_i) begin
        acc_q      <= rst_ni & icache_req.req & icache_rsp.ready & ~icache_req.kill_s1;
        acc_addr_q <= icache_req.vaddr;
    end

    always @(negedge clk_i) begin
        rnd = xorshift(rnd);
        icache_rsp.ready = rnd[0] | rnd[1];
        icache_rsp.valid = acc_q;
        icache_rsp.vaddr = acc_addr_q;
        icache_rsp.data  = program_word(acc_addr_q);
        // a slow decode fills the queue and forces replays
        entry_ready = slow_decode ? (rnd[8] & rnd[9]) : (rnd[8] | rnd[9]);
    end

    // --------------------------------------------------
    // reference stream model
    // --------------------------------------------------
    assign flush_now = flush_i | (rb.valid & rb.is_mispredict);
    assign take      = entry_valid & entry_ready & ~flush_now;

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            exp_addr <= BootAddr;
        end else if (set_pc_commit_i) begin
            exp_addr <= pc_commit_i + 32'd4;
        end else if (ex_valid_i) begin
            exp_addr <= trap_vector_base_i;
        end else if (eret_i) begin
            exp_addr <= epc_i;
        end else if (rb.valid && rb.is_mispredict) begin
            exp_addr <= rb.target;
        end else if (take) begin
            exp_addr <= (entry.cf_type != fetch_pkg::NoCF) ? entry.predict_address
                                                          : entry.address + 32'd4;
        end
        if (take) begin
            taken_cnt <= taken_cnt + 1;
            if (chk_valid && entry.address == chk_addr) chk_valid <= 1'b0;
        end
    end

    // the request stays on and a flush kills both cache stages
    a_cache_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        icache_req.req && (!flush_now || (icache_req.kill_s1 && icache_req.kill_s2)))
        else begin
            $display("ERROR %s: expected %b/%b/%b, actual %b/%b/%b", cur_test, 1'b1,
                     $sampled(icache_req.kill_s1 | flush_now),
                     $sampled(icache_req.kill_s2 | flush_now), $sampled(icache_req.req),
                     $sampled(icache_req.kill_s1), $sampled(icache_req.kill_s2));
            errors++;
        end

    a_stream_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take |-> entry.address == exp_addr)
        else begin
            $display("ERROR %s: expected %h, actual %h", cur_test,
                     $sampled(exp_addr), $sampled(entry.address));
            errors++;
        end

    a_stream_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take |-> entry.instr == program_word(entry.address))
        else begin
            $display("ERROR %s: expected %h, actual %h", cur_test,
                     program_word($sampled(entry.address)), $sampled(entry.instr));
            errors++;
        end

    a_jal_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take && entry.instr[6:0] == `FETCH_OP_JAL |-> entry.cf_type == fetch_pkg::Jump
        && entry.predict_address == jal_target(entry.address))
        else begin
            $display("ERROR %s: expected %0d/%h, actual %0d/%h", cur_test, fetch_pkg::Jump,
                     jal_target($sampled(entry.address)), $sampled(entry.cf_type),
                     $sampled(entry.predict_address));
            errors++;
        end

    // untrained branches follow the sign of their offset
    a_static_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take && entry.instr[6:0] == `FETCH_OP_BRANCH && !trained[entry.address[5:2]]
        |-> entry.cf_type == (entry.instr[31] ? fetch_pkg::Branch : fetch_pkg::NoCF))
        else begin
            $display("ERROR %s: expected %0d, actual %0d", cur_test,
                     $sampled(entry.instr[31]), $sampled(entry.cf_type));
            errors++;
        end

    a_expected_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take && chk_valid && entry.address == chk_addr |-> entry.cf_type == chk_cf
        && (chk_cf == fetch_pkg::NoCF || entry.predict_address == chk_target))
        else begin
            $display("ERROR %s: expected %0d/%h, actual %0d/%h", cur_test, chk_cf, chk_target,
                     $sampled(entry.cf_type), $sampled(entry.predict_address));
            errors++;
        end

    // --------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------
    task automatic wait_entries(input int n);
        int start;
        start = taken_cnt;
        while (taken_cnt < start + n) @(posedge clk_i);
    endtask

    task automatic wait_expect();
        while (chk_valid) @(posedge clk_i);
    endtask

    // one-cycle redirect, optionally arming a kind check on the new stream
    task automatic redirect(input logic mis, input logic er, input logic ex, input logic cm,
                            input logic [31:0] tgt, input logic arm, input logic [31:0] ca,
                            input fetch_pkg::cf_type_e cf, input logic [31:0] ct);
        @(negedge clk_i);
        rb = '0;
        rb.valid = mis;
        rb.is_mispredict = mis;
        rb.target = tgt;
        eret_i = er;
        ex_valid_i = ex;
        set_pc_commit_i = cm;
        if (cm) pc_commit_i = tgt;
        flush_i = er | ex | cm;
        chk_valid = arm;
        chk_addr = ca;
        chk_cf = cf;
        chk_target = ct;
        @(negedge clk_i);
        rb = '0;
        {eret_i, ex_valid_i, set_pc_commit_i, flush_i} = '0;
    endtask

    task automatic train(input logic [31:0] pc, input logic tk);
        @(negedge clk_i);
        rb = '0;
        rb.valid = 1'b1;
        rb.pc = pc;
        rb.is_taken = tk;
        rb.cf_type = fetch_pkg::Branch;
        trained[pc[5:2]] = 1'b1;
        @(negedge clk_i);
        rb = '0;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done, %0d errors", cur_test, errors - err_start);
    endtask

    // ends a hung run
    initial begin
        repeat (TestLen * 20) @(posedge clk_i);
        $display("timeout: the frontend stopped delivering entries during %s", cur_test);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_ni = 1'b0;
        {flush_i, flush_bp_i, eret_i, ex_valid_i, set_pc_commit_i} = '0;
        epc_i = 32'h1030;
        trap_vector_base_i = 32'h2000;
        pc_commit_i = '0;
        rb = '0;
        icache_rsp = '0;
        entry_ready = 1'b0;
        acc_q = 1'b0;
        acc_addr_q = '0;
        rnd = 32'h479819b0;
        slow_decode = 1'b1;
        chk_valid = 1'b0;
        chk_addr = '0;
        chk_target = '0;
        chk_cf = fetch_pkg::NoCF;
        trained = '0;
        {taken_cnt, errors, tests} = '0;
        cur_test = "reset";
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;

        start_test("stream");
        wait_entries(80);
        end_test();
        slow_decode = 1'b0;

        start_test("jal_static");
        redirect(0, 0, 0, 1, 32'h0ffc, 1, 32'h1000, fetch_pkg::Jump, 32'h1010);
        wait_expect();
        redirect(1, 0, 0, 0, 32'h1030, 1, 32'h1040, fetch_pkg::Branch, 32'h1010);
        wait_expect();
        end_test();

        start_test("bht");
        train(32'h1040, 1'b0);
        train(32'h1040, 1'b0);
        redirect(1, 0, 0, 0, 32'h1030, 1, 32'h1040, fetch_pkg::NoCF, 32'h0);
        wait_expect();
        train(32'h1010, 1'b1);
        train(32'h1010, 1'b1);
        redirect(1, 0, 0, 0, 32'h1010, 1, 32'h1010, fetch_pkg::Branch, 32'h1018);
        wait_expect();
        end_test();

        start_test("call_ret");
        redirect(1, 0, 0, 0, 32'h1014, 1, 32'h1124, fetch_pkg::Return, 32'h1024);
        wait_expect();
        end_test();

        // the first new entry is checked by the stream model
        start_test("redirect");
        redirect(0, 1, 0, 0, 32'h0, 0, 32'h0, fetch_pkg::NoCF, 32'h0);
        wait_entries(4);
        redirect(0, 0, 1, 0, 32'h0, 0, 32'h0, fetch_pkg::NoCF, 32'h0);
        wait_entries(4);
        redirect(0, 0, 0, 1, 32'h1038, 0, 32'h0, fetch_pkg::NoCF, 32'h0);
        wait_entries(4);
        redirect(0, 1, 1, 0, 32'h0, 0, 32'h0, fetch_pkg::NoCF, 32'h0);
        wait_entries(4);
        end_test();

        @(negedge clk_i);
        $display("%0d tests, %0d entries, %0d errors", tests, taken_cnt, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== fetch_frontend.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/branch_scan.sv
rtl/bht.sv
rtl/ras.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
dv/tb_fetch_frontend.sv
